//--- verilog/dma_pkg.sv
package dma_pkg;

    // Bus and stream sizing
    localparam int data_width = 32;
    localparam int addr_width = 32;
    localparam int strobe_width = data_width / 8;

    // Sizing of the transfer progress counter
    localparam int max_transfer_size = 65536;
    localparam int progress_width = $clog2(max_transfer_size);

    // Kept small so that a stalled memory can fill the buffer
    localparam int fifo_depth = 64;
    localparam int fifo_pointer_width = $clog2(fifo_depth);
    localparam int fifo_count_width = $clog2(fifo_depth + 1);

    // Byte offsets of the control registers
    localparam logic [7:0] reg_target_base = 8'h00;
    localparam logic [7:0] reg_transfer_size = 8'h04;
    localparam logic [7:0] reg_status = 8'h08;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic last;
    } stream_beat_t;

    typedef struct packed {
        logic awvalid;
        logic [addr_width-1:0] awaddr;
        logic [2:0] awprot;
        logic wvalid;
        logic [data_width-1:0] wdata;
        logic [strobe_width-1:0] wstrb;
        logic bready;
    } axil_write_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
    } axil_write_rsp_t;

    typedef struct packed {
        logic arvalid;
        logic [addr_width-1:0] araddr;
        logic [2:0] arprot;
        logic rready;
    } axil_read_req_t;

    typedef struct packed {
        logic arready;
        logic rvalid;
        logic [data_width-1:0] rdata;
        logic [1:0] rresp;
    } axil_read_rsp_t;

    // Settings handed from the register bank to the write engine
    typedef struct packed {
        logic [addr_width-1:0] target_base;
        logic [data_width-1:0] transfer_size;
    } dma_config_t;

endpackage

//--- verilog/axil_register_bank.sv
`timescale 1ns/10ps

module axil_register_bank import dma_pkg::*; (
    input logic clock,
    input logic reset,
    input axil_write_req_t write_req,
    output axil_write_rsp_t write_rsp,
    input axil_read_req_t read_req,
    output axil_read_rsp_t read_rsp,
    input logic busy,
    output dma_config_t config_out
);

    dma_config_t config_q;
    logic bvalid;
    logic rvalid;
    logic [data_width-1:0] rdata;
    logic write_accept;
    logic read_accept;

    // Merges the bytes selected by the strobe into the old register value
    function automatic logic [data_width-1:0] apply_strobe(
        input logic [data_width-1:0] old_value,
        input logic [data_width-1:0] new_value,
        input logic [strobe_width-1:0] strobe
    );
        logic [data_width-1:0] result;
        result = old_value;
        for (int i = 0; i < strobe_width; i++) begin
            if (strobe[i]) begin
                result[8*i +: 8] = new_value[8*i +: 8];
            end
        end
        return result;
    endfunction

    // Address and data are taken together, and only while no response waits
    assign write_accept = write_req.awvalid && write_req.wvalid && !bvalid;
    assign read_accept = read_req.arvalid && !rvalid;

    always_comb begin
        write_rsp.awready = write_accept;
        write_rsp.wready = write_accept;
        write_rsp.bvalid = bvalid;
        write_rsp.bresp = 2'b00;
        read_rsp.arready = !rvalid;
        read_rsp.rvalid = rvalid;
        read_rsp.rdata = rdata;
        read_rsp.rresp = 2'b00;
    end

    assign config_out = config_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            config_q <= '0;
            bvalid <= 1'b0;
        end else begin
            if (write_accept) begin
                bvalid <= 1'b1;
                // The status offset is read only, so a write there only gets a response
                case (write_req.awaddr[7:0])
                    reg_target_base: config_q.target_base <= apply_strobe(
                        config_q.target_base, write_req.wdata, write_req.wstrb);
                    reg_transfer_size: config_q.transfer_size <= apply_strobe(
                        config_q.transfer_size, write_req.wdata, write_req.wstrb);
                    default: ;
                endcase
            end else if (bvalid && write_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rvalid <= 1'b0;
        end else if (read_accept) begin
            rvalid <= 1'b1;
        end else if (rvalid && read_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (read_accept) begin
            case (read_req.araddr[7:0])
                reg_target_base: rdata <= config_q.target_base;
                reg_transfer_size: rdata <= config_q.transfer_size;
                reg_status: rdata <= {{(data_width-1){1'b0}}, busy};
                default: rdata <= '0;
            endcase
        end
    end

    bvalid_held: assert property (@(posedge clock) disable iff (!reset)
        bvalid && !write_req.bready |=> bvalid);

    rvalid_held: assert property (@(posedge clock) disable iff (!reset)
        rvalid && !read_req.rready |=> rvalid && $stable(rdata));

endmodule

//--- verilog/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo import dma_pkg::*; #(
    parameter type payload_t = stream_beat_t
)(
    input logic clock,
    input logic reset,
    input payload_t in_beat,
    input logic in_valid,
    output logic in_ready,
    output payload_t out_beat,
    output logic out_valid,
    input logic out_ready
);

    payload_t storage [fifo_depth];
    logic [fifo_pointer_width-1:0] write_pointer;
    logic [fifo_pointer_width-1:0] read_pointer;
    logic [fifo_count_width-1:0] count;
    logic push;
    logic pop;

    assign in_ready = count != fifo_depth[fifo_count_width-1:0];
    assign out_valid = count != '0;
    // Show-ahead output, the head entry is always visible
    assign out_beat = storage[read_pointer];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            storage[write_pointer] <= in_beat;
        end
    end

    // The depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_pointer <= '0;
            read_pointer <= '0;
            count <= '0;
        end else begin
            if (push) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (pop) begin
                read_pointer <= read_pointer + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // A beat refused while full has to stay on offer, or it would be lost
    refused_beat_held: assert property (@(posedge clock) disable iff (!reset)
        in_valid && !in_ready |=> in_valid && $stable(in_beat));

    // The consumer only asks for a word while one sits at the head
    no_pop_when_empty: assert property (@(posedge clock) disable iff (!reset)
        out_ready |-> out_valid);

endmodule

//--- verilog/axil_stream_writer.sv
`timescale 1ns/10ps

module axil_stream_writer import dma_pkg::*; (
    input logic clock,
    input logic reset,
    input logic start,
    input dma_config_t config_in,
    input stream_beat_t word_beat,
    input logic word_valid,
    output logic word_ready,
    output axil_write_req_t write_req,
    input axil_write_rsp_t write_rsp,
    output axil_read_req_t read_req,
    output logic busy
);

    typedef enum logic [1:0] {
        state_idle,
        state_issue,
        state_wait_response
    } writer_state_t;

    writer_state_t state;
    dma_config_t active_config;
    logic [progress_width-1:0] progress;
    logic [progress_width-1:0] last_index;
    logic [fifo_count_width-1:0] pending;
    logic [addr_width-1:0] awaddr;
    logic awvalid;
    logic wvalid;
    logic aw_done;
    logic w_done;
    logic take;
    logic launch;
    logic aw_handshake;
    logic w_handshake;

    // A queued transfer is picked up as soon as the engine is idle
    assign take = state == state_idle && pending != '0;
    // Both channels are raised together once a word sits at the FIFO head
    assign launch = state == state_issue && word_valid && !awvalid && !wvalid
        && !aw_done && !w_done;
    assign aw_handshake = awvalid && write_rsp.awready;
    assign w_handshake = wvalid && write_rsp.wready;
    assign last_index = active_config.transfer_size[progress_width-1:0] - 1'b1;

    // The head word is the write data, so it leaves the FIFO when the data is accepted
    assign word_ready = w_handshake;
    assign busy = start || pending != '0 || state != state_idle;

    always_comb begin
        write_req.awvalid = awvalid;
        write_req.awaddr = awaddr;
        write_req.awprot = 3'b000;
        write_req.wvalid = wvalid;
        write_req.wdata = word_beat.data;
        write_req.wstrb = '1;
        write_req.bready = 1'b1;
    end

    // Read side of the memory port is not used
    always_comb begin
        read_req.arvalid = 1'b0;
        read_req.araddr = '0;
        read_req.arprot = 3'b000;
        read_req.rready = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pending <= '0;
        end else if (start && !take) begin
            pending <= pending + 1'b1;
        end else if (take && !start) begin
            pending <= pending - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            active_config <= config_in;
        end
        if (launch) begin
            awaddr <= active_config.target_base + {progress, 2'b00};
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_idle;
            progress <= '0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (take) begin
                        progress <= '0;
                        state <= state_issue;
                    end
                end
                state_issue: begin
                    if (launch) begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                    end
                    if (aw_handshake) begin
                        awvalid <= 1'b0;
                        aw_done <= 1'b1;
                    end
                    if (w_handshake) begin
                        wvalid <= 1'b0;
                        w_done <= 1'b1;
                    end
                    // Leave once both channels have been accepted, in either order
                    if ((aw_done || aw_handshake) && (w_done || w_handshake)) begin
                        aw_done <= 1'b0;
                        w_done <= 1'b0;
                        state <= state_wait_response;
                    end
                end
                state_wait_response: begin
                    if (write_rsp.bvalid) begin
                        if (progress == last_index) begin
                            state <= state_idle;
                        end else begin
                            progress <= progress + 1'b1;
                            state <= state_issue;
                        end
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    awaddr_stable: assert property (@(posedge clock) disable iff (!reset)
        write_req.awvalid && !write_rsp.awready |=> write_req.awvalid
        && $stable(write_req.awaddr));

    pop_needs_data: assert property (@(posedge clock) disable iff (!reset)
        word_ready |-> word_valid);

endmodule

//--- verilog/axil_dma.sv
`timescale 1ns/10ps

module axil_dma import dma_pkg::*; (
    input logic clock,
    input logic reset,
    input axil_write_req_t ctrl_write_req,
    output axil_write_rsp_t ctrl_write_rsp,
    input axil_read_req_t ctrl_read_req,
    output axil_read_rsp_t ctrl_read_rsp,
    input stream_beat_t in_beat,
    input logic in_valid,
    output logic in_ready,
    output axil_write_req_t mem_write_req,
    input axil_write_rsp_t mem_write_rsp,
    output axil_read_req_t mem_read_req,
    input axil_read_rsp_t mem_read_rsp
);

    dma_config_t dma_config;
    stream_beat_t buffered_beat;
    logic buffered_valid;
    logic buffered_ready;
    logic busy;
    logic start;

    // A transfer is queued each time a packet end enters the buffer
    assign start = in_valid && in_ready && in_beat.last;

    axil_register_bank i_register_bank (
        .clock(clock),
        .reset(reset),
        .write_req(ctrl_write_req),
        .write_rsp(ctrl_write_rsp),
        .read_req(ctrl_read_req),
        .read_rsp(ctrl_read_rsp),
        .busy(busy),
        .config_out(dma_config)
    );

    stream_fifo #(
        .payload_t(stream_beat_t)
    ) i_stream_fifo (
        .clock(clock),
        .reset(reset),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_beat(buffered_beat),
        .out_valid(buffered_valid),
        .out_ready(buffered_ready)
    );

    axil_stream_writer i_stream_writer (
        .clock(clock),
        .reset(reset),
        .start(start),
        .config_in(dma_config),
        .word_beat(buffered_beat),
        .word_valid(buffered_valid),
        .word_ready(buffered_ready),
        .write_req(mem_write_req),
        .write_rsp(mem_write_rsp),
        .read_req(mem_read_req),
        .busy(busy)
    );

endmodule

//--- tb/axil_dma_tb.sv
`timescale 1ns/10ps

module axil_dma_tb import dma_pkg::*; ();

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } memory_write_t;

    localparam int cycles_per_line = 200;

    logic clock;
    logic reset;
    axil_write_req_t ctrl_write_req;
    axil_write_rsp_t ctrl_write_rsp;
    axil_read_req_t ctrl_read_req;
    axil_read_rsp_t ctrl_read_rsp;
    stream_beat_t in_beat;
    logic in_valid;
    logic in_ready;
    axil_write_req_t mem_write_req;
    axil_write_rsp_t mem_write_rsp;
    axil_read_req_t mem_read_req;
    axil_read_rsp_t mem_read_rsp;

    memory_write_t expected_writes[$];
    string stimulus_lines[$];
    int cycle_budget = 0;
    logic budget_ready = 1'b0;
    int mismatch_count = 0;
    int failure_count = 0;

    // State of the memory slave model
    integer seed = 32'h187d_3093;
    int stall_mode = 0;
    logic [31:0] stall_draw;
    logic have_addr = 1'b0;
    logic have_data = 1'b0;
    logic response_pending = 1'b0;
    logic [addr_width-1:0] captured_addr;
    logic [data_width-1:0] captured_data;

    axil_dma i_dut (
        .clock(clock),
        .reset(reset),
        .ctrl_write_req(ctrl_write_req),
        .ctrl_write_rsp(ctrl_write_rsp),
        .ctrl_read_req(ctrl_read_req),
        .ctrl_read_rsp(ctrl_read_rsp),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .mem_write_req(mem_write_req),
        .mem_write_rsp(mem_write_rsp),
        .mem_read_req(mem_read_req),
        .mem_read_rsp(mem_read_rsp)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    function automatic logic ready_allowed(input logic coin);
        return stall_mode == 0 || (stall_mode == 1 && coin);
    endfunction

    function automatic void check_memory_write(input logic [31:0] addr, input logic [31:0] data);
        memory_write_t expected;
        assert (expected_writes.size() != 0) else begin
            failure_count++;
            $display("unexpected memory write at %0t to address %h", $time, addr);
        end
        if (expected_writes.size() != 0) begin
            expected = expected_writes.pop_front();
            assert (addr == expected.addr && data == expected.data) else begin
                mismatch_count++;
                $display("mismatch at %0t: memory write %h to %h, expected %h to %h",
                    $time, data, addr, expected.data, expected.addr);
            end
        end
    endfunction

    // Memory slave model. Readies chosen here hold until the next falling edge,
    // so a handshake seen now completes on the coming rising edge
    always @(negedge clock) begin
        stall_draw = $random(seed);
        // The engine never reads, so its read channel stays idle
        assert (!mem_read_req.arvalid && mem_read_req.rready) else begin
            mismatch_count++;
            $display("mismatch at %0t: memory read channel arvalid %b rready %b",
                $time, mem_read_req.arvalid, mem_read_req.rready);
        end
        mem_write_rsp.awready = !have_addr && !response_pending && ready_allowed(stall_draw[0]);
        mem_write_rsp.wready = !have_data && !response_pending && ready_allowed(stall_draw[1]);
        mem_write_rsp.bvalid = response_pending && ready_allowed(stall_draw[2]);
        if (mem_write_rsp.bvalid && mem_write_req.bready) begin
            response_pending = 1'b0;
        end
        if (mem_write_req.awvalid && mem_write_rsp.awready) begin
            captured_addr = mem_write_req.awaddr;
            have_addr = 1'b1;
        end
        if (mem_write_req.wvalid && mem_write_rsp.wready) begin
            captured_data = mem_write_req.wdata;
            have_data = 1'b1;
            assert (mem_write_req.wstrb == {strobe_width{1'b1}}) else begin
                mismatch_count++;
                $display("mismatch at %0t: write strobe %b, expected all bytes enabled",
                    $time, mem_write_req.wstrb);
            end
        end
        if (have_addr && have_data) begin
            check_memory_write(captured_addr, captured_data);
            have_addr = 1'b0;
            have_data = 1'b0;
            response_pending = 1'b1;
        end
    end

    task automatic write_register(input logic [7:0] offset, input logic [31:0] value);
        @(negedge clock);
        ctrl_write_req.awvalid = 1'b1;
        ctrl_write_req.awaddr = {24'h0, offset};
        ctrl_write_req.wvalid = 1'b1;
        ctrl_write_req.wdata = value;
        // The response rising shows that address and data were taken
        do begin
            @(negedge clock);
        end while (!ctrl_write_rsp.bvalid);
        ctrl_write_req.awvalid = 1'b0;
        ctrl_write_req.wvalid = 1'b0;
    endtask

    task automatic read_register(input logic [7:0] offset, output logic [31:0] value);
        @(negedge clock);
        ctrl_read_req.arvalid = 1'b1;
        ctrl_read_req.araddr = {24'h0, offset};
        do begin
            @(negedge clock);
        end while (!ctrl_read_rsp.rvalid);
        value = ctrl_read_rsp.rdata;
        ctrl_read_req.arvalid = 1'b0;
    endtask

    // A beat is only offered while the buffer has room, so it is taken on the next edge
    task automatic send_beat(input logic [31:0] data, input logic last);
        @(negedge clock);
        while (!in_ready) begin
            in_valid = 1'b0;
            @(negedge clock);
        end
        in_beat = '{data: data, last: last};
        in_valid = 1'b1;
    endtask

    task automatic stop_stream();
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int count, input logic [31:0] first_data,
        input logic [31:0] first_addr, input logic last);
        for (int i = 0; i < count; i++) begin
            expected_writes.push_back(memory_write_t'{addr: first_addr + 32'(4 * i),
                data: first_data + 32'(i)});
            send_beat(first_data + 32'(i), last && i == count - 1);
        end
        stop_stream();
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        status = 32'h1;
        while (status[0]) begin
            read_register(reg_status, status);
        end
        assert (expected_writes.size() == 0) else begin
            failure_count++;
            $display("transfer ended at %0t with %0d memory writes still missing",
                $time, expected_writes.size());
        end
    endtask

    task automatic run_command(input string line);
        byte op;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] third;
        logic [31:0] fourth;
        logic [31:0] value;
        op = line.getc(0);
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
            first, second, third, fourth));
        case (op)
            "W": write_register(first[7:0], second);
            "R": begin
                read_register(first[7:0], value);
                assert (value == second) else begin
                    mismatch_count++;
                    $display("mismatch at %0t: register %h read %h, expected %h",
                        $time, first[7:0], value, second);
                end
            end
            "S": begin
                send_beat(first, second[0]);
                stop_stream();
            end
            "E": expected_writes.push_back(memory_write_t'{addr: first, data: second});
            "G": send_packet(int'(first), second, third, fourth[0]);
            "T": stall_mode = int'(first);
            "F": begin
                @(negedge clock);
                while (in_ready) begin
                    @(negedge clock);
                end
            end
            "P": wait_idle();
            default: begin
                failure_count++;
                $display("unknown command in stimulus file: %s", line);
            end
        endcase
    endtask

    initial begin
        integer fd;
        string line;
        int count;
        ctrl_write_req = '0;
        ctrl_write_req.wstrb = '1;
        ctrl_write_req.bready = 1'b1;
        ctrl_read_req = '0;
        ctrl_read_req.rready = 1'b1;
        in_beat = '0;
        in_valid = 1'b0;
        mem_write_rsp = '0;
        mem_read_rsp = '0;
        reset = 1'b0;
        fd = $fopen("tb/axil_dma_stimulus.txt", "r");
        if (fd == 0) begin
            failure_count++;
            $display("could not open the stimulus file tb/axil_dma_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    stimulus_lines.push_back(line);
                    cycle_budget += cycles_per_line;
                    // Packet lines stream many beats, so they get time per beat
                    if (line.getc(0) == "G") begin
                        count = 0;
                        void'($sscanf(line.substr(1, line.len() - 1), "%h", count));
                        cycle_budget += cycles_per_line * count;
                    end
                end
            end
            $fclose(fd);
        end
        budget_ready = 1'b1;
        // Two rising edges see reset low before it is released
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        foreach (stimulus_lines[i]) begin
            run_command(stimulus_lines[i]);
        end
        repeat (4) @(negedge clock);
        assert (expected_writes.size() == 0) else begin
            failure_count++;
            $display("%0d expected memory writes never arrived", expected_writes.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (budget_ready);
        repeat (cycle_budget + 10) @(posedge clock);
        $display("timeout: stimulus did not finish within %0d clock cycles", cycle_budget);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb/axil_dma_stimulus.txt
# op and hex operands: W offset value, R offset expected, S data last, E address data
# G count first_data first_address last, T stall (0 off, 1 random, 2 hold), F wait full, P idle
R 8 0
W 0 1000
W 4 8
R 0 1000
R 4 8
W 8 ffffffff
R 8 0
R 0 1000
T 0
E 1000 a0000000
E 1004 a0000001
E 1008 a0000002
E 100c a0000003
E 1010 a0000004
E 1014 a0000005
E 1018 a0000006
E 101c a0000007
S a0000000 0
S a0000001 0
S a0000002 0
S a0000003 0
S a0000004 0
S a0000005 0
S a0000006 0
S a0000007 1
P
R 8 0
T 1
W 0 2000
W 4 10
G 10 b0000000 2000 1
P
W 4 c
G c c0000000 2000 1
W 0 3000
W 4 6
G 6 d0000000 3000 1
P
R 0 3000
R 4 6
W 0 4000
W 4 50
T 2
G 10 e0000000 4000 1
G 30 e0000010 4040 0
F
T 1
G 10 e0000040 4100 0
P
T 0
R 8 0

//--- axil_dma.f
verilog/dma_pkg.sv
verilog/axil_register_bank.sv
verilog/stream_fifo.sv
verilog/axil_stream_writer.sv
verilog/axil_dma.sv
tb/axil_dma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= axil_dma_tb
FILE_LIST ?= axil_dma.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
